/* wbuf.f */
+incdir+verilog
verilog/wbuf_pkg.sv
verilog/wbuf_fifo.sv
verilog/wbuf_data_store.sv
verilog/wbuf_send.sv
verilog/wbuf_dir.sv
verilog/wbuf.sv
verif/wbuf_clkgen.sv
verif/wbuf_properties.sv
verif/wbuf_tb.sv

/* Makefile */
TOOL     := verilator
FLAGS    := --binary --timing --assert --timescale 1ns/100ps
TOP      := wbuf_tb
FILELIST := wbuf.f
OBJ_DIR  := obj_dir
PASS_MSG := Simulation finished: PASS

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Output is shown in full and then searched for the pass line
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* verif/wbuf_tb.sv */
`timescale 1ns/100ps
`default_nettype none
`include "wbuf_params.svh"

module wbuf_tb;
    import wbuf_pkg::*;

    localparam int N_LINES     = 8;
    localparam int N_CACHEABLE = 6;
    localparam int RAND_CYCLES = 2000;
    localparam int STIM_CYCLES = RAND_CYCLES + 100;
    localparam int TIMEOUT     = 20 * STIM_CYCLES;
    localparam int WORD_BYTES  = `WBUF_WORD_WIDTH / 8;

    logic          clk;
    logic          rst_n;
    logic          empty;
    logic          full;
    logic          flush_all;
    wbuf_cfg_t     cfg;
    logic          wr_en;
    wbuf_write_t   wr_s;
    logic          wr_ready;
    wbuf_addr_u    rd_s;
    logic          rd_flush;
    logic          rd_hit;
    logic          req_valid;
    logic          req_ready;
    wbuf_mem_req_t req;
    logic          data_valid;
    logic          data_ready;
    wbuf_line_t    data_line;
    logic          resp_valid;
    wbuf_id_t      resp_id;

    // Byte images, indexed by byte address
    logic [7:0]    ref_img [int];
    logic [7:0]    mem_img [int];
    wbuf_mem_req_t req_q [$];
    wbuf_line_t    data_q [$];
    wbuf_id_t      ack_q [$];

    wbuf_cfg_t     cfg_sel;
    logic          flush_hold;
    int            line_cap;
    logic          chk_now;
    logic          chk_next;
    int            chk_line;
    int            n_req;
    int            n_ack;
    int            n_errors;
    int            cycles;
    int            req_before;
    int            ack_before;

    wbuf_clkgen #(
        .PERIOD       (100),
        .RESET_CYCLES (2)
    ) clkgen_i (
        .clk_o  (clk),
        .rst_no (rst_n)
    );

    wbuf wbuf_i (
        .clk_i            (clk),
        .rst_ni           (rst_n),
        .empty_o          (empty),
        .full_o           (full),
        .flush_all_i      (flush_all),
        .cfg_i            (cfg),
        .write_i          (wr_en),
        .write_s_i        (wr_s),
        .write_ready_o    (wr_ready),
        .read_s_i         (rd_s),
        .read_flush_i     (rd_flush),
        .read_hit_o       (rd_hit),
        .mem_req_valid_o  (req_valid),
        .mem_req_ready_i  (req_ready),
        .mem_req_o        (req),
        .mem_data_valid_o (data_valid),
        .mem_data_ready_i (data_ready),
        .mem_data_o       (data_line),
        .mem_resp_valid_i (resp_valid),
        .mem_resp_id_i    (resp_id)
    );

    // Tags spread out so every line sits in its own cache line
    function automatic wbuf_tag_t line_tag(input int k);
        return wbuf_tag_t'(32'h200 + 3 * k);
    endfunction

    function automatic int line_index(input wbuf_tag_t tag);
        for (int k = 0; k < N_LINES; k++) begin
            if (line_tag(k) == tag) begin
                return k;
            end
        end
        return -1;
    endfunction

    task automatic abort_run();
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            n_errors++;
            $display("[FAIL] %0t: %s, got %b expected %b", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_req(input wbuf_mem_req_t got, input wbuf_mem_req_t exp,
                             input string what);
        if (got !== exp) begin
            n_errors++;
            $display("[FAIL] %0t: %s, got %h expected %h", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_line(input wbuf_line_t got, input wbuf_line_t exp, input string what);
        if (got !== exp) begin
            n_errors++;
            $display("[FAIL] %0t: %s, got %h expected %h", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic record_write(input wbuf_write_t ws);
        int base;
        base = int'({ws.addr.b.tag, ws.addr.b.widx, 2'b00});
        for (int b = 0; b < WORD_BYTES; b++) begin
            if (ws.be[b]) begin
                ref_img[base + b] = ws.data[b*8 +: 8];
            end
        end
    endtask

    task automatic take_req(input wbuf_mem_req_t r);
        wbuf_mem_req_t exp;
        int            k;
        k = line_index(r.line_addr);
        check_bit(k >= 0, 1'b1, "request for a line that was never written");
        exp           = r;
        exp.cacheable = (k < N_CACHEABLE);
        check_req(r, exp, "request cacheable flag");
        req_q.push_back(r);
        n_req++;
    endtask

    // Pair the oldest request with the oldest data line
    task automatic apply_transfer();
        wbuf_mem_req_t r;
        wbuf_line_t    ln;
        int            base;
        r    = req_q.pop_front();
        ln   = data_q.pop_front();
        base = int'({r.line_addr, 3'b000});
        check_bit(|ln.be, 1'b1, "data line without byte enables");
        for (int w = 0; w < `WBUF_LINE_WORDS; w++) begin
            for (int b = 0; b < WORD_BYTES; b++) begin
                if (ln.be[w][b]) begin
                    mem_img[base + w*WORD_BYTES + b] = ln.data[w][b*8 +: 8];
                end
            end
        end
        ack_q.push_back(r.id);
    endtask

    task automatic run_cycle(input int write_pct, input logic flush_en);
        wbuf_addr_u rd;
        int         k;
        int         idx;
        int         wr_line;
        @(posedge clk);
        #10;
        cfg        = cfg_sel;
        wr_en      = 1'b0;
        resp_valid = 1'b0;
        rd_flush   = flush_en && ($urandom % 16 == 0);
        flush_all  = flush_hold || (flush_en && ($urandom % 64 == 0));
        req_ready  = ($urandom % 4) != 0;
        data_ready = ($urandom % 4) != 0;
        chk_now    = chk_next;
        chk_next   = 1'b0;
        wr_line    = 0;
        k          = chk_now ? chk_line : int'($urandom % N_LINES);
        rd         = '0;
        rd.b.tag   = line_tag(k);
        // Any byte of the cache line
        rd.l.loff  = 4'($urandom);
        rd_s       = rd;
        if (int'($urandom % 100) < write_pct) begin
            wr_line          = int'($urandom % line_cap);
            wr_s.addr        = '0;
            wr_s.addr.b.tag  = line_tag(wr_line);
            wr_s.addr.b.widx = ($urandom % 2) != 0;
            wr_s.data        = $urandom;
            wr_s.be          = wbuf_be_t'($urandom % 15 + 1);
            wr_s.uc          = (wr_line >= N_CACHEABLE);
            wr_en            = 1'b1;
        end
        if ((ack_q.size() > 0) && ($urandom % 3 == 0)) begin
            idx        = int'($urandom % ack_q.size());
            resp_id    = ack_q[idx];
            resp_valid = 1'b1;
            ack_q.delete(idx);
            n_ack++;
        end
        @(negedge clk);
        if (wr_en && wr_ready) begin
            record_write(wr_s);
            chk_next = 1'b1;
            chk_line = wr_line;
        end
        if (chk_now) begin
            check_bit(rd_hit, 1'b1, "read hit in the cycle after a write");
        end
        if (req_valid && req_ready) begin
            take_req(req);
        end
        if (data_valid && data_ready) begin
            data_q.push_back(data_line);
        end
        while ((req_q.size() > 0) && (data_q.size() > 0)) begin
            apply_transfer();
        end
    endtask

    task automatic probe_no_hit(input int k);
        wbuf_addr_u rd;
        @(posedge clk);
        #10;
        wr_en      = 1'b0;
        resp_valid = 1'b0;
        rd         = '0;
        rd.b.tag   = line_tag(k);
        rd_s       = rd;
        @(negedge clk);
        check_bit(rd_hit, 1'b0, "read hit after the buffer drained");
        check_bit(empty, 1'b1, "buffer not empty after the final flush");
    endtask

    task automatic check_final_line(input int k);
        wbuf_line_t got;
        wbuf_line_t exp;
        int         a;
        got = '0;
        exp = '0;
        for (int w = 0; w < `WBUF_LINE_WORDS; w++) begin
            for (int b = 0; b < WORD_BYTES; b++) begin
                a = int'({line_tag(k), 3'b000}) + w*WORD_BYTES + b;
                if (ref_img.exists(a)) begin
                    exp.be[w][b]           = 1'b1;
                    exp.data[w][b*8 +: 8]  = ref_img[a];
                end
                if (mem_img.exists(a)) begin
                    got.be[w][b]           = 1'b1;
                    got.data[w][b*8 +: 8]  = mem_img[a];
                end
            end
        end
        check_line(got, exp, $sformatf("memory image of line %0d", k));
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT);
            abort_run();
        end
    end

    initial begin
        void'($urandom(32'h716a76dc));
        flush_all  = 1'b0;
        cfg        = '0;
        wr_en      = 1'b0;
        wr_s       = '0;
        rd_s       = '0;
        rd_flush   = 1'b0;
        req_ready  = 1'b0;
        data_ready = 1'b0;
        resp_valid = 1'b0;
        resp_id    = '0;
        cfg_sel    = '0;
        flush_hold = 1'b0;
        line_cap   = N_LINES;
        chk_now    = 1'b0;
        chk_next   = 1'b0;
        chk_line   = 0;
        n_req      = 0;
        n_ack      = 0;
        n_errors   = 0;
        cycles     = 0;

        @(posedge rst_n);
        @(negedge clk);
        check_bit(empty, 1'b1, "empty after reset");
        check_bit(full, 1'b0, "full after reset");
        check_bit(req_valid, 1'b0, "request valid after reset");
        check_bit(data_valid, 1'b0, "data valid after reset");

        // One cacheable write left to the idle timer
        cfg_sel.threshold   = 4'd2;
        cfg_sel.reset_timer = 1'b0;
        line_cap            = N_CACHEABLE;
        req_before          = n_req;
        ack_before          = n_ack;
        run_cycle(100, 1'b0);
        check_bit(chk_next, 1'b1, "single write accepted");
        while (!(empty && (n_ack > ack_before))) begin
            run_cycle(0, 1'b0);
        end
        check_bit(n_req == req_before + 1, 1'b1, "one request for the single write");

        line_cap            = N_LINES;
        cfg_sel.threshold   = 4'd5;
        cfg_sel.reset_timer = 1'b1;
        repeat (RAND_CYCLES / 2) run_cycle(60, 1'b1);

        // Instant send, heavier traffic
        cfg_sel.threshold   = 4'd0;
        cfg_sel.reset_timer = 1'b0;
        repeat (RAND_CYCLES / 2) run_cycle(80, 1'b1);

        flush_hold = 1'b1;
        run_cycle(0, 1'b0);
        while (!empty) begin
            run_cycle(0, 1'b0);
        end
        check_bit((req_q.size() == 0) && (data_q.size() == 0) && (ack_q.size() == 0),
                  1'b1, "transfers left unmatched after the drain");
        for (int k = 0; k < N_LINES; k++) begin
            probe_no_hit(k);
        end
        for (int k = 0; k < N_LINES; k++) begin
            check_final_line(k);
        end

        if (n_errors == 0) begin
            $display("Simulation finished: PASS");
            $finish;
        end else begin
            abort_run();
        end
    end

endmodule

`default_nettype wire

/* verif/wbuf_properties.sv */
`timescale 1ns/100ps
`default_nettype none
`include "wbuf_params.svh"

module wbuf_properties (
    input  logic                                        clk_i,
    input  logic                                        rst_ni,
    input  wbuf_pkg::wbuf_state_e [`WBUF_ENTRIES-1:0]   state_i,
    input  logic                                        mem_resp_valid_i,
    input  wbuf_pkg::wbuf_id_t                          mem_resp_id_i,
    input  logic                                        empty_i,
    input  logic                                        mem_req_valid_i,
    input  logic                                        mem_req_ready_i,
    input  wbuf_pkg::wbuf_mem_req_t                     mem_req_i
);
    import wbuf_pkg::*;

    // Only a sent entry may be acknowledged
    ack_sent_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        mem_resp_valid_i |-> (state_i[mem_resp_id_i] == WBUF_SENT))
        else $error("acknowledge for entry %0d which is not sent", mem_resp_id_i);

    // Nothing left in the request queue once every entry is free
    empty_idle_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        empty_i |-> !mem_req_valid_i)
        else $error("memory request pending while the buffer is empty");

    // Held request keeps valid and payload
    req_stable_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (mem_req_valid_i && !mem_req_ready_i) |=> (mem_req_valid_i && $stable(mem_req_i)))
        else $error("memory request changed while held back");

endmodule

bind wbuf wbuf_properties props_i (
    .clk_i,
    .rst_ni,
    .state_i          (dir_i.state_q),
    .mem_resp_valid_i,
    .mem_resp_id_i,
    .empty_i          (empty_o),
    .mem_req_valid_i  (mem_req_valid_o),
    .mem_req_ready_i,
    .mem_req_i        (mem_req_o)
);

`default_nettype wire

/* verif/wbuf_clkgen.sv */
`timescale 1ns/100ps
`default_nettype none

module wbuf_clkgen #(
    parameter int unsigned PERIOD       = 100,
    parameter int unsigned RESET_CYCLES = 2
) (
    output logic clk_o,
    output logic rst_no
);
    initial begin
        clk_o = 1'b0;
        forever begin
            #(PERIOD / 2) clk_o = ~clk_o;
        end
    end

    // Release just after the last reset edge
    initial begin
        rst_no = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #10 rst_no = 1'b1;
    end

endmodule

`default_nettype wire

/* verilog/wbuf.sv */
`timescale 1ns/100ps
`default_nettype none
`include "wbuf_params.svh"

module wbuf (
    input  logic                         clk_i,
    input  logic                         rst_ni,
    output logic                         empty_o,
    output logic                         full_o,
    input  logic                         flush_all_i,
    input  wbuf_pkg::wbuf_cfg_t          cfg_i,
    input  logic                         write_i,
    input  wbuf_pkg::wbuf_write_t        write_s_i,
    output logic                         write_ready_o,
    input  wbuf_pkg::wbuf_addr_u         read_s_i,
    input  logic                         read_flush_i,
    output logic                         read_hit_o,
    output logic                         mem_req_valid_o,
    input  logic                         mem_req_ready_i,
    output wbuf_pkg::wbuf_mem_req_t      mem_req_o,
    output logic                         mem_data_valid_o,
    input  logic                         mem_data_ready_i,
    output wbuf_pkg::wbuf_line_t         mem_data_o,
    input  logic                         mem_resp_valid_i,
    input  logic [`WBUF_ID_WIDTH-1:0]    mem_resp_id_i
);
    import wbuf_pkg::*;

    logic [`WBUF_ENTRIES-1:0]            pend;
    wbuf_tag_t [`WBUF_ENTRIES-1:0]       tags;
    logic [`WBUF_ENTRIES-1:0]            uc;
    logic [`WBUF_ENTRIES-1:0]            pick;
    logic                                push;
    logic                                store_we;
    wbuf_id_t                            store_id;
    logic                                store_fresh;
    wbuf_id_t                            head_id;

    wbuf_dir dir_i (
        .clk_i,
        .rst_ni,
        .flush_all_i,
        .cfg_i,
        .write_i,
        .write_s_i,
        .write_ready_o,
        .read_s_i,
        .read_flush_i,
        .read_hit_o,
        .empty_o,
        .full_o,
        .pend_o           (pend),
        .tags_o           (tags),
        .uc_o             (uc),
        .pick_i           (pick),
        .push_i           (push),
        .store_we_o       (store_we),
        .store_id_o       (store_id),
        .store_fresh_o    (store_fresh),
        .mem_resp_valid_i,
        .mem_resp_id_i
    );

    // Line data is read by the id at the head of the data queue
    wbuf_data_store data_store_i (
        .clk_i,
        .we_i      (store_we),
        .wid_i     (store_id),
        .fresh_i   (store_fresh),
        .write_s_i,
        .rid_i     (head_id),
        .line_o    (mem_data_o)
    );

    wbuf_send send_i (
        .clk_i,
        .rst_ni,
        .pend_i           (pend),
        .tags_i           (tags),
        .uc_i             (uc),
        .pick_o           (pick),
        .push_o           (push),
        .mem_req_valid_o,
        .mem_req_ready_i,
        .mem_req_o,
        .head_id_o        (head_id),
        .mem_data_valid_o,
        .mem_data_ready_i
    );

endmodule

`default_nettype wire

/* verilog/wbuf_dir.sv */
`timescale 1ns/100ps
`default_nettype none
`include "wbuf_params.svh"

module wbuf_dir (
    input  logic                                    clk_i,
    input  logic                                    rst_ni,
    input  logic                                    flush_all_i,
    input  wbuf_pkg::wbuf_cfg_t                     cfg_i,
    input  logic                                    write_i,
    input  wbuf_pkg::wbuf_write_t                   write_s_i,
    output logic                                    write_ready_o,
    input  wbuf_pkg::wbuf_addr_u                    read_s_i,
    input  logic                                    read_flush_i,
    output logic                                    read_hit_o,
    output logic                                    empty_o,
    output logic                                    full_o,
    output logic [`WBUF_ENTRIES-1:0]                pend_o,
    output wbuf_pkg::wbuf_tag_t [`WBUF_ENTRIES-1:0] tags_o,
    output logic [`WBUF_ENTRIES-1:0]                uc_o,
    input  logic [`WBUF_ENTRIES-1:0]                pick_i,
    input  logic                                    push_i,
    output logic                                    store_we_o,
    output wbuf_pkg::wbuf_id_t                      store_id_o,
    output logic                                    store_fresh_o,
    input  logic                                    mem_resp_valid_i,
    input  wbuf_pkg::wbuf_id_t                      mem_resp_id_i
);
    import wbuf_pkg::*;

    localparam int unsigned N = `WBUF_ENTRIES;

    wbuf_state_e [N-1:0]                    state_q, state_d;
    wbuf_tag_t   [N-1:0]                    tag_q;
    logic        [N-1:0]                    uc_q;
    logic [N-1:0][`WBUF_TIMECNT_WIDTH-1:0]  cnt_q, cnt_d;

    logic [N-1:0]   free_vec, hit_vec, line_hit_vec;
    logic [N-1:0]   merge_vec, flush_vec, timeout_vec;
    logic           hit_any, free_any, accept, alloc, instant_send;
    wbuf_id_t       hit_id, free_id;
    wbuf_tag_t      write_tag;

    assign write_tag = write_s_i.addr.b.tag;

    for (genvar i = 0; i < N; i++) begin : gen_entry
        wbuf_addr_u entry_addr;

        // Rebuild the line base address to compare in cache-line terms
        assign entry_addr      = {tag_q[i], {`WBUF_LINE_OFFSET_WIDTH{1'b0}}};
        assign free_vec[i]     = (state_q[i] == WBUF_FREE);
        assign pend_o[i]       = (state_q[i] == WBUF_PEND);
        assign hit_vec[i]      = ((state_q[i] == WBUF_OPEN) || (state_q[i] == WBUF_PEND))
                                 && (tag_q[i] == write_tag);
        assign line_hit_vec[i] = !free_vec[i] && (entry_addr.l.nline == read_s_i.l.nline);
        assign merge_vec[i]    = accept && hit_vec[i];
        assign flush_vec[i]    = read_flush_i && line_hit_vec[i];
        assign timeout_vec[i]  = (cnt_q[i] == cfg_i.threshold - 1'b1);
    end

    // Lowest index wins for both searches
    always_comb begin
        hit_id  = '0;
        free_id = '0;
        for (int i = N - 1; i >= 0; i--) begin
            if (hit_vec[i]) begin
                hit_id = wbuf_id_t'(i);
            end
            if (free_vec[i]) begin
                free_id = wbuf_id_t'(i);
            end
        end
    end

    assign hit_any       = |hit_vec;
    assign free_any      = |free_vec;
    assign write_ready_o = hit_any | free_any;
    assign accept        = write_i & write_ready_o;
    assign alloc         = accept & ~hit_any;
    assign instant_send  = (cfg_i.threshold == '0) | write_s_i.uc | flush_all_i;

    assign store_we_o    = accept;
    assign store_id_o    = hit_any ? hit_id : free_id;
    assign store_fresh_o = ~hit_any;

    assign read_hit_o = |line_hit_vec;
    assign empty_o    = &free_vec;
    assign full_o     = ~free_any;
    assign tags_o     = tag_q;
    assign uc_o       = uc_q;

    always_comb begin
        state_d = state_q;
        cnt_d   = cnt_q;
        for (int i = 0; i < N; i++) begin
            unique case (state_q[i])
                WBUF_FREE: begin
                    if (alloc && (free_id == wbuf_id_t'(i))) begin
                        state_d[i] = instant_send ? WBUF_PEND : WBUF_OPEN;
                        cnt_d[i]   = '0;
                    end
                end
                WBUF_OPEN: begin
                    if (merge_vec[i] && cfg_i.reset_timer) begin
                        cnt_d[i] = '0;
                    end else if (!timeout_vec[i]) begin
                        cnt_d[i] = cnt_q[i] + 1'b1;
                    end
                    // A merge that restarts the timer cancels this cycle's timeout
                    if (flush_all_i || flush_vec[i] || (cfg_i.threshold == '0) ||
                        (timeout_vec[i] && !(merge_vec[i] && cfg_i.reset_timer))) begin
                        state_d[i] = WBUF_PEND;
                    end
                end
                WBUF_PEND: begin
                    if (push_i && pick_i[i]) begin
                        state_d[i] = WBUF_SENT;
                    end
                end
                WBUF_SENT: begin
                    if (mem_resp_valid_i && (mem_resp_id_i == wbuf_id_t'(i))) begin
                        state_d[i] = WBUF_FREE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int i = 0; i < N; i++) begin
                state_q[i] <= WBUF_FREE;
            end
            cnt_q <= '0;
        end else begin
            state_q <= state_d;
            cnt_q   <= cnt_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (alloc) begin
            tag_q[free_id] <= write_tag;
            uc_q[free_id]  <= write_s_i.uc;
        end
    end

endmodule

`default_nettype wire

/* verilog/wbuf_send.sv */
`timescale 1ns/100ps
`default_nettype none
`include "wbuf_params.svh"

module wbuf_send (
    input  logic                                    clk_i,
    input  logic                                    rst_ni,
    input  logic [`WBUF_ENTRIES-1:0]                pend_i,
    input  wbuf_pkg::wbuf_tag_t [`WBUF_ENTRIES-1:0] tags_i,
    input  logic [`WBUF_ENTRIES-1:0]                uc_i,
    output logic [`WBUF_ENTRIES-1:0]                pick_o,
    output logic                                    push_o,
    output logic                                    mem_req_valid_o,
    input  logic                                    mem_req_ready_i,
    output wbuf_pkg::wbuf_mem_req_t                 mem_req_o,
    output wbuf_pkg::wbuf_id_t                      head_id_o,
    output logic                                    mem_data_valid_o,
    input  logic                                    mem_data_ready_i
);
    import wbuf_pkg::*;

    localparam int unsigned N = `WBUF_ENTRIES;

    wbuf_id_t       ptr_q;
    wbuf_id_t       win_id;
    logic           found;
    logic           req_wok;
    logic           data_wok;
    wbuf_mem_req_t  req_d;

    // Round-robin search starting at the pointer
    always_comb begin
        int unsigned idx;
        found  = 1'b0;
        win_id = ptr_q;
        pick_o = '0;
        for (int unsigned k = 0; k < N; k++) begin
            idx = (int'(ptr_q) + k) % N;
            if (!found && pend_i[idx]) begin
                found  = 1'b1;
                win_id = wbuf_id_t'(idx);
            end
        end
        if (found) begin
            pick_o[win_id] = 1'b1;
        end
    end

    // Both queues must have room, so request and data stay in step
    assign push_o = found & req_wok & data_wok;

    assign req_d.line_addr = tags_i[win_id];
    assign req_d.id        = win_id;
    assign req_d.cacheable = ~uc_i[win_id];

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            ptr_q <= '0;
        end else if (push_o) begin
            ptr_q <= (int'(win_id) == N - 1) ? '0 : win_id + 1'b1;
        end
    end

    wbuf_fifo #(
        .fifo_data_t (wbuf_mem_req_t)
    ) req_fifo_i (
        .clk_i,
        .rst_ni,
        .w_i     (push_o),
        .wok_o   (req_wok),
        .wdata_i (req_d),
        .r_i     (mem_req_ready_i),
        .rok_o   (mem_req_valid_o),
        .rdata_o (mem_req_o)
    );

    wbuf_fifo #(
        .fifo_data_t (wbuf_id_t)
    ) data_fifo_i (
        .clk_i,
        .rst_ni,
        .w_i     (push_o),
        .wok_o   (data_wok),
        .wdata_i (win_id),
        .r_i     (mem_data_ready_i),
        .rok_o   (mem_data_valid_o),
        .rdata_o (head_id_o)
    );

endmodule

`default_nettype wire

/* verilog/wbuf_data_store.sv */
`timescale 1ns/100ps
`default_nettype none
`include "wbuf_params.svh"

module wbuf_data_store (
    input  logic                     clk_i,
    input  logic                     we_i,
    input  wbuf_pkg::wbuf_id_t       wid_i,
    input  logic                     fresh_i,
    input  wbuf_pkg::wbuf_write_t    write_s_i,
    input  wbuf_pkg::wbuf_id_t       rid_i,
    output wbuf_pkg::wbuf_line_t     line_o
);
    import wbuf_pkg::*;

    localparam int unsigned WORD_BYTES = `WBUF_WORD_WIDTH / 8;

    wbuf_line_t lines_q [`WBUF_ENTRIES];
    wbuf_line_t line_old;
    wbuf_line_t line_new;

    assign line_old = lines_q[wid_i];

    // Byte merge into the word slot selected by the address
    always_comb begin
        line_new = line_old;
        if (fresh_i) begin
            line_new.be = '0;
        end
        for (int w = 0; w < `WBUF_LINE_WORDS; w++) begin
            if (w == int'(write_s_i.addr.b.widx)) begin
                for (int b = 0; b < WORD_BYTES; b++) begin
                    if (write_s_i.be[b]) begin
                        line_new.data[w][b*8 +: 8] = write_s_i.data[b*8 +: 8];
                    end
                end
                line_new.be[w] = line_new.be[w] | write_s_i.be;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (we_i) begin
            lines_q[wid_i] <= line_new;
        end
    end

    assign line_o = lines_q[rid_i];

endmodule

`default_nettype wire

/* verilog/wbuf_fifo.sv */
`timescale 1ns/100ps
`default_nettype none
`include "wbuf_params.svh"

module wbuf_fifo #(
    parameter type         fifo_data_t = logic,
    parameter int unsigned DEPTH       = `WBUF_ENTRIES
) (
    input  logic       clk_i,
    input  logic       rst_ni,
    input  logic       w_i,
    output logic       wok_o,
    input  fifo_data_t wdata_i,
    input  logic       r_i,
    output logic       rok_o,
    output fifo_data_t rdata_o
);
    localparam int unsigned PTR_WIDTH = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    fifo_data_t             mem_q [DEPTH];
    logic [PTR_WIDTH-1:0]   wptr_q, rptr_q;
    logic [PTR_WIDTH:0]     cnt_q;
    logic                   do_w, do_r;

    assign wok_o   = (cnt_q != (PTR_WIDTH+1)'(DEPTH));
    assign rok_o   = (cnt_q != '0);
    assign do_w    = w_i & wok_o;
    assign do_r    = r_i & rok_o;
    assign rdata_o = mem_q[rptr_q];

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wptr_q <= '0;
            rptr_q <= '0;
            cnt_q  <= '0;
        end else begin
            if (do_w) begin
                wptr_q <= (int'(wptr_q) == DEPTH - 1) ? '0 : wptr_q + 1'b1;
            end
            if (do_r) begin
                rptr_q <= (int'(rptr_q) == DEPTH - 1) ? '0 : rptr_q + 1'b1;
            end
            // Simultaneous read and write leaves the count unchanged
            if (do_w && !do_r) begin
                cnt_q <= cnt_q + 1'b1;
            end else if (do_r && !do_w) begin
                cnt_q <= cnt_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (do_w) begin
            mem_q[wptr_q] <= wdata_i;
        end
    end

endmodule

`default_nettype wire

/* verilog/wbuf_pkg.sv */
`default_nettype none
`include "wbuf_params.svh"

package wbuf_pkg;

    typedef logic [`WBUF_ADDR_WIDTH-`WBUF_LINE_OFFSET_WIDTH-1:0] wbuf_tag_t;
    typedef logic [`WBUF_ID_WIDTH-1:0] wbuf_id_t;
    typedef logic [`WBUF_WORD_WIDTH-1:0] wbuf_word_t;
    typedef logic [`WBUF_WORD_WIDTH/8-1:0] wbuf_be_t;

    // Address as seen by the buffer directory
    typedef struct packed {
        wbuf_tag_t tag;
        logic [`WBUF_LINE_OFFSET_WIDTH-$clog2(`WBUF_WORD_WIDTH/8)-1:0] widx;
        logic [$clog2(`WBUF_WORD_WIDTH/8)-1:0] boff;
    } wbuf_addr_buf_t;

    // Address as seen by the cache
    typedef struct packed {
        logic [`WBUF_ADDR_WIDTH-`WBUF_NLINE_OFFSET_WIDTH-1:0] nline;
        logic [`WBUF_NLINE_OFFSET_WIDTH-1:0] loff;
    } wbuf_addr_line_t;

    typedef union packed {
        wbuf_addr_buf_t  b;
        wbuf_addr_line_t l;
    } wbuf_addr_u;

    typedef enum logic [1:0] {
        WBUF_FREE = 2'b00,
        WBUF_OPEN = 2'b01,
        WBUF_PEND = 2'b10,
        WBUF_SENT = 2'b11
    } wbuf_state_e;

    typedef struct packed {
        wbuf_addr_u addr;
        wbuf_word_t data;
        wbuf_be_t   be;
        logic       uc;
    } wbuf_write_t;

    typedef struct packed {
        logic [`WBUF_TIMECNT_WIDTH-1:0] threshold;
        logic                           reset_timer;
    } wbuf_cfg_t;

    // Line address carries the tag only, offset bits are implied zero
    typedef struct packed {
        wbuf_tag_t line_addr;
        wbuf_id_t  id;
        logic      cacheable;
    } wbuf_mem_req_t;

    typedef struct packed {
        wbuf_word_t [`WBUF_LINE_WORDS-1:0] data;
        wbuf_be_t   [`WBUF_LINE_WORDS-1:0] be;
    } wbuf_line_t;

endpackage

`default_nettype wire

/* verilog/wbuf_params.svh */
`ifndef WBUF_PARAMS_SVH
`define WBUF_PARAMS_SVH

// Directory size and entry id
`define WBUF_ENTRIES 4
`define WBUF_ID_WIDTH 2

// Address and data widths
`define WBUF_ADDR_WIDTH 16
`define WBUF_WORD_WIDTH 32
`define WBUF_LINE_WORDS 2
`define WBUF_LINE_OFFSET_WIDTH 3
`define WBUF_NLINE_OFFSET_WIDTH 4

// Idle timer of an open entry
`define WBUF_TIMECNT_WIDTH 4

`endif
